/* hw/dlx_pkg.sv */
package dlx_pkg;

  // datapath widths
  localparam int word_w = 32;
  localparam int reg_addr_w = 5;

  ////////////////////
  // opcodes
  localparam logic [5:0] op_special = 6'h00;
  localparam logic [5:0] op_j = 6'h02;
  localparam logic [5:0] op_jal = 6'h03;
  localparam logic [5:0] op_beqz = 6'h04;
  localparam logic [5:0] op_bnez = 6'h05;
  localparam logic [5:0] op_addi = 6'h08;
  localparam logic [5:0] op_andi = 6'h0c;
  localparam logic [5:0] op_ori = 6'h0d;
  localparam logic [5:0] op_xori = 6'h0e;
  localparam logic [5:0] op_lhi = 6'h0f;
  localparam logic [5:0] op_jr = 6'h12;
  localparam logic [5:0] op_jalr = 6'h13;
  localparam logic [5:0] op_slti = 6'h18;
  localparam logic [5:0] op_lb = 6'h20;
  localparam logic [5:0] op_lh = 6'h21;
  localparam logic [5:0] op_lw = 6'h23;
  localparam logic [5:0] op_lbu = 6'h24;
  localparam logic [5:0] op_lhu = 6'h25;
  localparam logic [5:0] op_sb = 6'h28;
  localparam logic [5:0] op_sh = 6'h29;
  localparam logic [5:0] op_sw = 6'h2b;

  ////////////////////
  // function codes, doubling as alu ops
  localparam logic [5:0] fn_sll = 6'h04;
  localparam logic [5:0] fn_srl = 6'h06;
  localparam logic [5:0] fn_sra = 6'h07;
  localparam logic [5:0] fn_add = 6'h20;
  localparam logic [5:0] fn_sub = 6'h22;
  localparam logic [5:0] fn_and = 6'h24;
  localparam logic [5:0] fn_or = 6'h25;
  localparam logic [5:0] fn_xor = 6'h26;
  localparam logic [5:0] fn_slt = 6'h2a;

  // operand source in execute, 2'b11 unused
  localparam logic [1:0] fwd_reg = 2'b00;
  localparam logic [1:0] fwd_wb = 2'b01;
  localparam logic [1:0] fwd_mem = 2'b10;

  // jal / jalr destination
  localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

  // one instruction word, three formats
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [reg_addr_w-1:0] rs1;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rd;
      logic [10:0] func;
    } r;
    struct packed {
      logic [5:0] opcode;
      logic [reg_addr_w-1:0] rs1;
      logic [reg_addr_w-1:0] rs2;
      logic [15:0] imm16;
    } i;
    struct packed {
      logic [5:0] opcode;
      logic [25:0] imm26;
    } j;
  } instr_t;

endpackage

/* hw/dlx_fetch.sv */
`timescale 1ns/1ps

module dlx_fetch (
  input  logic clk,
  input  logic rst,
  input  logic stall,
  input  logic branch_taken,
  input  logic jump,
  input  logic jump_reg,
  input  logic [15:0] imm16,
  input  logic [25:0] imm26,
  input  logic [dlx_pkg::word_w-1:0] target_reg,
  input  logic [dlx_pkg::word_w-1:0] pc_plus4,
  output logic [dlx_pkg::word_w-1:0] pc
);
  import dlx_pkg::*;

  logic [word_w-1:0] next_pc;

  // offsets are relative to the decode-stage pc plus four
  always_comb begin
    next_pc = pc + 32'd4;
    if (branch_taken)
      next_pc = pc_plus4 + {{16{imm16[15]}}, imm16};
    else if (jump)
      next_pc = pc_plus4 + {{6{imm26[25]}}, imm26};
    else if (jump_reg)
      next_pc = target_reg;
  end

  // stall holds the pc, so a stalled branch cannot redirect
  always_ff @(posedge clk) begin
    if (rst)
      pc <= '0;
    else if (!stall)
      pc <= next_pc;
  end

  // decoder never raises two redirect kinds at once
  a_one_redirect: assert property (@(posedge clk) disable iff (rst)
    !(jump && (branch_taken || jump_reg)));

endmodule

/* hw/dlx_decode.sv */
`timescale 1ns/1ps

module dlx_decode (
  input  dlx_pkg::instr_t instr,
  output logic reg_wr,
  output logic r_type,
  output logic branch_z,
  output logic branch_nz,
  output logic jump,
  output logic jump_reg,
  output logic link,
  output logic imm_inst,
  output logic imm_zero_ext,
  output logic load_unsigned,
  output logic mem_to_reg,
  output logic lb,
  output logic lh,
  output logic lhi,
  output logic sb,
  output logic sh,
  output logic mem_wr,
  output logic uses_rs2,
  output logic [5:0] alu_op
);
  import dlx_pkg::*;

  logic [5:0] op;

  assign op = instr.i.opcode;

  always_comb begin
    // nop unless the opcode says otherwise
    {reg_wr, r_type, branch_z, branch_nz, jump, jump_reg, link} = '0;
    {imm_inst, imm_zero_ext, load_unsigned, mem_to_reg, lb, lh, lhi} = '0;
    {sb, sh, mem_wr, uses_rs2} = '0;
    alu_op = fn_add;
    case (op)
      op_special: begin
        r_type = 1'b1;
        uses_rs2 = 1'b1;
        alu_op = instr.r.func[5:0];
        // unknown function codes write nothing
        reg_wr = instr.r.func[5:0] inside {fn_add, fn_sub, fn_and, fn_or, fn_xor,
                                            fn_slt, fn_sll, fn_srl, fn_sra};
      end
      op_addi, op_slti: begin
        reg_wr = 1'b1;
        imm_inst = 1'b1;
        alu_op = (op == op_slti) ? fn_slt : fn_add;
      end
      // logical immediates are zero extended
      op_andi, op_ori, op_xori: begin
        reg_wr = 1'b1;
        imm_inst = 1'b1;
        imm_zero_ext = 1'b1;
        if (op == op_andi)
          alu_op = fn_and;
        else
          alu_op = (op == op_ori) ? fn_or : fn_xor;
      end
      op_lhi: begin
        reg_wr = 1'b1;
        lhi = 1'b1;
      end
      // address is rs1 plus signed imm16
      op_lb, op_lbu, op_lh, op_lhu, op_lw: begin
        reg_wr = 1'b1;
        imm_inst = 1'b1;
        mem_to_reg = 1'b1;
        lb = (op == op_lb) || (op == op_lbu);
        lh = (op == op_lh) || (op == op_lhu);
        load_unsigned = (op == op_lbu) || (op == op_lhu);
      end
      // store data rides in the rs2 field
      op_sb, op_sh, op_sw: begin
        mem_wr = 1'b1;
        imm_inst = 1'b1;
        uses_rs2 = 1'b1;
        sb = (op == op_sb);
        sh = (op == op_sh);
      end
      op_beqz: branch_z = 1'b1;
      op_bnez: branch_nz = 1'b1;
      op_j, op_jal: begin
        jump = 1'b1;
        link = (op == op_jal);
        reg_wr = (op == op_jal);
      end
      op_jr, op_jalr: begin
        jump_reg = 1'b1;
        link = (op == op_jalr);
        reg_wr = (op == op_jalr);
      end
      default: ;
    endcase
  end

endmodule

/* hw/dlx_reg_file.sv */
`timescale 1ns/1ps

module dlx_reg_file (
  input  logic clk,
  input  logic rst,
  input  logic [dlx_pkg::reg_addr_w-1:0] rs1,
  input  logic [dlx_pkg::reg_addr_w-1:0] rs2,
  input  logic wr_en,
  input  logic [dlx_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [dlx_pkg::word_w-1:0] wr_data,
  output logic [dlx_pkg::word_w-1:0] bus_a,
  output logic [dlx_pkg::word_w-1:0] bus_b
);
  import dlx_pkg::*;

  logic [word_w-1:0] regs [1 << reg_addr_w];

  // r0 is never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < (1 << reg_addr_w); k++) begin
        regs[k] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign bus_a = (wr_en && wr_addr != '0 && wr_addr == rs1) ? wr_data : regs[rs1];
  assign bus_b = (wr_en && wr_addr != '0 && wr_addr == rs2) ? wr_data : regs[rs2];

  a_r0_zero: assert property (@(posedge clk) disable iff (rst)
    (rs1 == '0) |-> (bus_a == '0));

endmodule

/* hw/dlx_hazard.sv */
`timescale 1ns/1ps

module dlx_hazard (
  input  logic [dlx_pkg::reg_addr_w-1:0] id_rs1,
  input  logic [dlx_pkg::reg_addr_w-1:0] id_rs2,
  input  logic id_uses_rs2,
  input  logic id_reads_rs1_branch,
  input  logic [dlx_pkg::reg_addr_w-1:0] ex_rs1,
  input  logic [dlx_pkg::reg_addr_w-1:0] ex_rs2,
  input  logic [dlx_pkg::reg_addr_w-1:0] ex_rd,
  input  logic ex_load,
  input  logic ex_reg_wr,
  input  logic [dlx_pkg::reg_addr_w-1:0] mem_rd,
  input  logic mem_reg_wr,
  input  logic [dlx_pkg::reg_addr_w-1:0] wb_rd,
  input  logic wb_reg_wr,
  output logic stall,
  output logic [1:0] fwd_a,
  output logic [1:0] fwd_b
);
  import dlx_pkg::*;

  logic load_use;
  logic branch_dep;

  // nearest producer wins
  // r0 is never forwarded
  function automatic logic [1:0] fwd_sel(input logic [reg_addr_w-1:0] src);
    if (mem_reg_wr && mem_rd != '0 && mem_rd == src)
      return fwd_mem;
    if (wb_reg_wr && wb_rd != '0 && wb_rd == src)
      return fwd_wb;
    return fwd_reg;
  endfunction

  always_comb begin
    // load in execute with its consumer in decode
    load_use = ex_load && ex_rd != '0 &&
               (ex_rd == id_rs1 || (id_uses_rs2 && ex_rd == id_rs2));
    // branch / jr source still in execute or memory
    branch_dep = id_reads_rs1_branch && id_rs1 != '0 &&
                 ((ex_reg_wr && ex_rd == id_rs1) || (mem_reg_wr && mem_rd == id_rs1));
    stall = load_use || branch_dep;
    fwd_a = fwd_sel(ex_rs1);
    fwd_b = fwd_sel(ex_rs2);
  end

endmodule

/* hw/dlx_execute.sv */
`timescale 1ns/1ps

module dlx_execute (
  input  logic [dlx_pkg::word_w-1:0] bus_a,
  input  logic [dlx_pkg::word_w-1:0] bus_b,
  input  logic [dlx_pkg::word_w-1:0] mem_result,
  input  logic [dlx_pkg::word_w-1:0] wb_result,
  input  logic [1:0] fwd_a,
  input  logic [1:0] fwd_b,
  input  logic [5:0] alu_op,
  input  logic imm_inst,
  input  logic imm_zero_ext,
  input  logic [15:0] imm16,
  output logic [dlx_pkg::word_w-1:0] store_data,
  output logic [dlx_pkg::word_w-1:0] alu_out
);
  import dlx_pkg::*;

  logic [word_w-1:0] op_a;
  logic [word_w-1:0] op_b;
  logic [word_w-1:0] imm_ext;

  function automatic logic [word_w-1:0] fwd_mux(input logic [1:0] sel,
                                                input logic [word_w-1:0] reg_val);
    case (sel)
      fwd_mem: return mem_result;
      fwd_wb: return wb_result;
      default: return reg_val;
    endcase
  endfunction

  always_comb begin
    op_a = fwd_mux(fwd_a, bus_a);
    // forwarded b doubles as store data
    store_data = fwd_mux(fwd_b, bus_b);
    imm_ext = imm_zero_ext ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};
    op_b = imm_inst ? imm_ext : store_data;
    // shift amount from low five bits of b
    case (alu_op)
      fn_add: alu_out = op_a + op_b;
      fn_sub: alu_out = op_a - op_b;
      fn_and: alu_out = op_a & op_b;
      fn_or: alu_out = op_a | op_b;
      fn_xor: alu_out = op_a ^ op_b;
      fn_slt: alu_out = {{(word_w - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
      fn_sll: alu_out = op_a << op_b[4:0];
      fn_srl: alu_out = op_a >> op_b[4:0];
      fn_sra: alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
      default: alu_out = '0;
    endcase
  end

endmodule

/* hw/dlx_write_back.sv */
`timescale 1ns/1ps

module dlx_write_back (
  input  logic [dlx_pkg::word_w-1:0] mem_data,
  input  logic [dlx_pkg::word_w-1:0] alu_out,
  input  logic [dlx_pkg::word_w-1:0] pc_plus4,
  input  logic [15:0] imm16,
  input  logic [1:0] byte_lane,
  input  logic mem_to_reg,
  input  logic lb,
  input  logic lh,
  input  logic load_unsigned,
  input  logic lhi,
  input  logic link,
  output logic [dlx_pkg::word_w-1:0] wb_data
);
  import dlx_pkg::*;

  logic [7:0] byte_val;
  logic [15:0] half_val;
  logic [word_w-1:0] load_val;

  always_comb begin
    // little-endian lanes of the aligned word
    byte_val = mem_data[{byte_lane, 3'b000} +: 8];
    half_val = byte_lane[1] ? mem_data[31:16] : mem_data[15:0];
    if (lb)
      load_val = load_unsigned ? {24'b0, byte_val} : {{24{byte_val[7]}}, byte_val};
    else if (lh)
      load_val = load_unsigned ? {16'b0, half_val} : {{16{half_val[15]}}, half_val};
    else
      load_val = mem_data;
    // link writes the address past the delay slot
    if (lhi)
      wb_data = {imm16, 16'h0000};
    else if (link)
      wb_data = pc_plus4 + 32'd4;
    else if (mem_to_reg)
      wb_data = load_val;
    else
      wb_data = alu_out;
  end

endmodule

/* hw/dlx_pipeline.sv */
`timescale 1ns/1ps

module dlx_pipeline (
  input  logic clk,
  input  logic rst,
  input  logic [dlx_pkg::word_w-1:0] instruction,
  input  logic [dlx_pkg::word_w-1:0] mem_read_data,
  output logic [dlx_pkg::word_w-1:0] pc,
  output logic [dlx_pkg::word_w-1:0] mem_addr,
  output logic [dlx_pkg::word_w-1:0] mem_write_data,
  output logic mem_wr,
  output logic mem_sb,
  output logic mem_sh
);
  import dlx_pkg::*;

  // control groups
  // ex:  {r_type, imm_inst, imm_zero_ext, alu_op[5:0]}
  // mem: {mem_wr, sb, sh}
  // wb:  {mem_to_reg, lb, lh, load_unsigned, lhi, link}

  // decoder outputs
  logic dec_reg_wr, dec_r_type, dec_branch_z, dec_branch_nz, dec_jump, dec_jump_reg;
  logic dec_link, dec_imm_inst, dec_imm_zero_ext, dec_load_unsigned, dec_mem_to_reg;
  logic dec_lb, dec_lh, dec_lhi, dec_sb, dec_sh, dec_mem_wr, dec_uses_rs2;
  logic [5:0] dec_alu_op;

  // if/id
  logic if_id_valid;
  instr_t if_id_instr;
  logic [word_w-1:0] if_id_pc4;
  // id/ex
  logic id_ex_valid, id_ex_reg_wr;
  logic [8:0] id_ex_ex_ctrl;
  logic [2:0] id_ex_mem_ctrl;
  logic [5:0] id_ex_wb_ctrl;
  instr_t id_ex_instr;
  logic [word_w-1:0] id_ex_pc4, id_ex_bus_a, id_ex_bus_b;
  // ex/mem
  logic ex_mem_valid, ex_mem_reg_wr;
  logic [2:0] ex_mem_mem_ctrl;
  logic [5:0] ex_mem_wb_ctrl;
  instr_t ex_mem_instr;
  logic [word_w-1:0] ex_mem_pc4, ex_mem_alu_out, ex_mem_store_data;
  logic [reg_addr_w-1:0] ex_mem_rd;
  // mem/wb
  logic mem_wb_valid, mem_wb_reg_wr;
  logic [5:0] mem_wb_wb_ctrl;
  instr_t mem_wb_instr;
  logic [word_w-1:0] mem_wb_pc4, mem_wb_alu_out, mem_wb_mem_data;
  logic [reg_addr_w-1:0] mem_wb_rd;

  // stage nets
  logic stall, id_go, branch_taken;
  logic [1:0] fwd_a, fwd_b;
  logic [word_w-1:0] id_bus_a, id_bus_b, ex_alu_out, ex_store_data;
  logic [word_w-1:0] mem_fwd_data, wb_data;
  logic [reg_addr_w-1:0] ex_rd;

  ////////////////////
  // fetch
  dlx_fetch u_fetch (
    .clk(clk), .rst(rst), .stall(stall), .branch_taken(branch_taken),
    .jump(if_id_valid & dec_jump), .jump_reg(if_id_valid & dec_jump_reg),
    .imm16(if_id_instr.i.imm16), .imm26(if_id_instr.j.imm26),
    .target_reg(id_bus_a), .pc_plus4(if_id_pc4), .pc(pc)
  );

  ////////////////////
  // decode
  dlx_decode u_decode (
    .instr(if_id_instr), .reg_wr(dec_reg_wr), .r_type(dec_r_type),
    .branch_z(dec_branch_z), .branch_nz(dec_branch_nz), .jump(dec_jump),
    .jump_reg(dec_jump_reg), .link(dec_link), .imm_inst(dec_imm_inst),
    .imm_zero_ext(dec_imm_zero_ext), .load_unsigned(dec_load_unsigned),
    .mem_to_reg(dec_mem_to_reg), .lb(dec_lb), .lh(dec_lh), .lhi(dec_lhi),
    .sb(dec_sb), .sh(dec_sh), .mem_wr(dec_mem_wr), .uses_rs2(dec_uses_rs2),
    .alu_op(dec_alu_op)
  );

  dlx_reg_file u_reg_file (
    .clk(clk), .rst(rst), .rs1(if_id_instr.r.rs1), .rs2(if_id_instr.r.rs2),
    .wr_en(mem_wb_valid & mem_wb_reg_wr), .wr_addr(mem_wb_rd), .wr_data(wb_data),
    .bus_a(id_bus_a), .bus_b(id_bus_b)
  );

  // beqz / bnez test rs1 in decode
  assign branch_taken = if_id_valid &&
                        ((dec_branch_z && id_bus_a == '0) || (dec_branch_nz && id_bus_a != '0));
  assign id_go = if_id_valid && !stall;

  // valid bits folded into the write enables
  dlx_hazard u_hazard (
    .id_rs1(if_id_instr.r.rs1), .id_rs2(if_id_instr.r.rs2),
    .id_uses_rs2(if_id_valid & dec_uses_rs2),
    .id_reads_rs1_branch(if_id_valid & (dec_branch_z | dec_branch_nz | dec_jump_reg)),
    .ex_rs1(id_ex_instr.r.rs1), .ex_rs2(id_ex_instr.r.rs2), .ex_rd(ex_rd),
    .ex_load(id_ex_valid & id_ex_wb_ctrl[5]), .ex_reg_wr(id_ex_valid & id_ex_reg_wr),
    .mem_rd(ex_mem_rd), .mem_reg_wr(ex_mem_valid & ex_mem_reg_wr),
    .wb_rd(mem_wb_rd), .wb_reg_wr(mem_wb_valid & mem_wb_reg_wr),
    .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  ////////////////////
  // execute
  // rd for r-type, r31 for link, rs2 field otherwise
  assign ex_rd = id_ex_ex_ctrl[8] ? id_ex_instr.r.rd :
                 (id_ex_wb_ctrl[0] ? link_reg : id_ex_instr.i.rs2);

  dlx_execute u_execute (
    .bus_a(id_ex_bus_a), .bus_b(id_ex_bus_b), .mem_result(mem_fwd_data),
    .wb_result(wb_data), .fwd_a(fwd_a), .fwd_b(fwd_b), .alu_op(id_ex_ex_ctrl[5:0]),
    .imm_inst(id_ex_ex_ctrl[7]), .imm_zero_ext(id_ex_ex_ctrl[6]),
    .imm16(id_ex_instr.i.imm16), .store_data(ex_store_data), .alu_out(ex_alu_out)
  );

  ////////////////////
  // memory
  assign mem_addr = ex_mem_alu_out;
  assign mem_write_data = ex_mem_store_data;
  assign mem_wr = ex_mem_valid & ex_mem_mem_ctrl[2];
  assign mem_sb = ex_mem_valid & ex_mem_mem_ctrl[1];
  assign mem_sh = ex_mem_valid & ex_mem_mem_ctrl[0];

  // memory-stage value for forwarding, lhi and link included, load data not
  dlx_write_back u_mem_fwd (
    .mem_data(mem_read_data), .alu_out(ex_mem_alu_out), .pc_plus4(ex_mem_pc4),
    .imm16(ex_mem_instr.i.imm16), .byte_lane(ex_mem_alu_out[1:0]),
    .mem_to_reg(1'b0), .lb(1'b0), .lh(1'b0), .load_unsigned(1'b0),
    .lhi(ex_mem_wb_ctrl[1]), .link(ex_mem_wb_ctrl[0]), .wb_data(mem_fwd_data)
  );

  ////////////////////
  // write-back
  dlx_write_back u_write_back (
    .mem_data(mem_wb_mem_data), .alu_out(mem_wb_alu_out), .pc_plus4(mem_wb_pc4),
    .imm16(mem_wb_instr.i.imm16), .byte_lane(mem_wb_alu_out[1:0]),
    .mem_to_reg(mem_wb_wb_ctrl[5]), .lb(mem_wb_wb_ctrl[4]), .lh(mem_wb_wb_ctrl[3]),
    .load_unsigned(mem_wb_wb_ctrl[2]), .lhi(mem_wb_wb_ctrl[1]),
    .link(mem_wb_wb_ctrl[0]), .wb_data(wb_data)
  );

  ////////////////////
  // pipeline registers, control side
  always_ff @(posedge clk) begin
    if (rst) begin
      {if_id_valid, id_ex_valid, ex_mem_valid, mem_wb_valid} <= '0;
      {id_ex_reg_wr, id_ex_ex_ctrl, id_ex_mem_ctrl, id_ex_wb_ctrl} <= '0;
      {ex_mem_reg_wr, ex_mem_mem_ctrl, ex_mem_wb_ctrl} <= '0;
      {mem_wb_reg_wr, mem_wb_wb_ctrl} <= '0;
    end else begin
      if_id_valid <= 1'b1;
      // bubble on stall
      id_ex_valid <= id_go;
      if (id_go) begin
        id_ex_reg_wr <= dec_reg_wr;
        id_ex_ex_ctrl <= {dec_r_type, dec_imm_inst, dec_imm_zero_ext, dec_alu_op};
        id_ex_mem_ctrl <= {dec_mem_wr, dec_sb, dec_sh};
        id_ex_wb_ctrl <= {dec_mem_to_reg, dec_lb, dec_lh, dec_load_unsigned, dec_lhi,
                          dec_link};
      end else begin
        {id_ex_reg_wr, id_ex_ex_ctrl, id_ex_mem_ctrl, id_ex_wb_ctrl} <= '0;
      end
      {ex_mem_valid, ex_mem_reg_wr} <= {id_ex_valid, id_ex_reg_wr};
      {ex_mem_mem_ctrl, ex_mem_wb_ctrl} <= {id_ex_mem_ctrl, id_ex_wb_ctrl};
      {mem_wb_valid, mem_wb_reg_wr, mem_wb_wb_ctrl} <= {ex_mem_valid, ex_mem_reg_wr,
                                                        ex_mem_wb_ctrl};
    end
  end

  // payload side
  always_ff @(posedge clk) begin
    if (!stall) begin
      if_id_instr <= instruction;
      if_id_pc4 <= pc + 32'd4;
    end
    id_ex_instr <= if_id_instr;
    id_ex_pc4 <= if_id_pc4;
    id_ex_bus_a <= id_bus_a;
    id_ex_bus_b <= id_bus_b;
    ex_mem_instr <= id_ex_instr;
    ex_mem_pc4 <= id_ex_pc4;
    ex_mem_rd <= ex_rd;
    ex_mem_alu_out <= ex_alu_out;
    ex_mem_store_data <= ex_store_data;
    mem_wb_instr <= ex_mem_instr;
    mem_wb_pc4 <= ex_mem_pc4;
    mem_wb_rd <= ex_mem_rd;
    mem_wb_alu_out <= ex_mem_alu_out;
    mem_wb_mem_data <= mem_read_data;
  end

  // store size strobes are exclusive and only ride a write
  a_store_size: assert property (@(posedge clk) disable iff (rst)
    (mem_sb || mem_sh) |-> (mem_wr && !(mem_sb && mem_sh)));

endmodule

/* sim/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// expected stores in program order
// size is {sb, sh}
logic [31:0] exp_addr [0:31];
logic [31:0] exp_data [0:31];
logic [1:0] exp_size [0:31];
int n_prog;
int n_exp;

////////////////////
// instruction encoders
function automatic logic [31:0] enc_r(input logic [5:0] fn, input int rd, input int rs1,
                                      input int rs2);
  return {op_special, rs1[4:0], rs2[4:0], rd[4:0], 5'b00000, fn};
endfunction

// rt is the destination or the store source
function automatic logic [31:0] enc_i(input logic [5:0] op, input int rt, input int rs1,
                                      input int imm);
  return {op, rs1[4:0], rt[4:0], imm[15:0]};
endfunction

function automatic logic [31:0] enc_j(input logic [5:0] op, input int off);
  return {op, off[25:0]};
endfunction

task automatic add_instr(input logic [31:0] w);
  prog[n_prog] = w;
  n_prog++;
endtask

task automatic add_store(input int addr, input logic [31:0] data, input logic [1:0] size);
  exp_addr[n_exp] = addr;
  exp_data[n_exp] = data;
  exp_size[n_exp] = size;
  n_exp++;
endtask

task automatic init_tables();
  n_prog = 0;
  n_exp = 0;
  for (int k = 0; k < 128; k++) begin
    prog[k] = '0;
  end
  // fill tagged with the word address
  for (int k = 0; k < 256; k++) begin
    dmem[k] = {16'h5a5a, 6'b000000, k[7:0], 2'b00};
  end
  dmem[128] = 32'hc3a57f81;
  // dependent alu chain forwarding from mem and wb
  add_instr(enc_i(op_addi, 1, 0, 16'h0123));
  add_instr(enc_i(op_addi, 2, 1, -1));
  add_instr(enc_r(fn_add, 3, 1, 2));
  add_instr(enc_i(op_sw, 3, 0, 16'h0100));
  // logical immediates zero extend
  add_instr(enc_i(op_ori, 4, 0, 16'h8001));
  add_instr(enc_i(op_xori, 5, 4, 16'hffff));
  add_instr(enc_i(op_andi, 6, 5, 16'hf0f0));
  add_instr(enc_i(op_sw, 6, 0, 16'h0104));
  add_instr(enc_r(fn_sub, 7, 6, 1));
  add_instr(enc_r(fn_slt, 8, 1, 7));
  add_instr(enc_r(fn_add, 9, 7, 8));
  add_instr(enc_i(op_sw, 9, 0, 16'h0108));
  // shifts and lhi
  add_instr(enc_i(op_lhi, 10, 0, 16'h8000));
  add_instr(enc_i(op_addi, 12, 0, 4));
  add_instr(enc_r(fn_sra, 11, 10, 12));
  add_instr(enc_r(fn_srl, 13, 10, 12));
  add_instr(enc_r(fn_sll, 14, 1, 12));
  add_instr(enc_r(fn_or, 15, 11, 14));
  add_instr(enc_r(fn_xor, 15, 15, 13));
  add_instr(enc_i(op_sw, 15, 0, 16'h010c));
  add_instr(enc_i(op_slti, 16, 10, 0));
  add_instr(enc_r(fn_add, 16, 16, 10));
  add_instr(enc_i(op_sw, 16, 0, 16'h0110));
  // loads on all four lanes with the store right behind
  add_instr(enc_i(op_addi, 20, 0, 16'h0200));
  add_instr(enc_i(op_lb, 21, 20, 1));
  add_instr(enc_i(op_sw, 21, 0, 16'h0114));
  add_instr(enc_i(op_lb, 22, 20, 0));
  add_instr(enc_i(op_sw, 22, 0, 16'h0118));
  add_instr(enc_i(op_lbu, 23, 20, 3));
  add_instr(enc_i(op_sw, 23, 0, 16'h011c));
  add_instr(enc_i(op_lh, 24, 20, 2));
  add_instr(enc_i(op_sw, 24, 0, 16'h0120));
  add_instr(enc_i(op_lhu, 25, 20, 2));
  add_instr(enc_i(op_sw, 25, 0, 16'h0124));
  add_instr(enc_i(op_lbu, 26, 20, 2));
  add_instr(enc_i(op_lh, 27, 20, 0));
  add_instr(enc_r(fn_add, 28, 26, 27));
  add_instr(enc_i(op_sw, 28, 0, 16'h0128));
  add_instr(enc_i(op_lw, 29, 20, 0));
  add_instr(enc_i(op_sw, 29, 0, 16'h012c));
  // partial stores then a read of the merged word
  add_instr(enc_i(op_sb, 1, 20, 1));
  add_instr(enc_i(op_sh, 4, 20, 2));
  add_instr(enc_i(op_lw, 30, 20, 0));
  add_instr(enc_i(op_sw, 30, 0, 16'h0130));
  // branch right after its source is written
  add_instr(enc_i(op_addi, 1, 0, 0));
  add_instr(enc_i(op_beqz, 0, 1, 8));
  add_instr(enc_i(op_sw, 3, 0, 16'h0134));
  add_instr(enc_i(op_sw, 3, 0, 16'h01e0));
  add_instr(enc_i(op_bnez, 0, 1, 8));
  // xori result with clear upper half
  add_instr(enc_i(op_sw, 5, 0, 16'h0138));
  add_instr(enc_i(op_sw, 9, 0, 16'h013c));
  add_instr(enc_i(op_bnez, 0, 3, 8));
  // andi on r15 drops its upper half
  add_instr(enc_i(op_andi, 2, 15, 16'hff55));
  add_instr(enc_i(op_sw, 2, 0, 16'h01e4));
  add_instr(enc_i(op_sw, 2, 0, 16'h0140));
  add_instr(enc_i(op_beqz, 0, 3, 8));
  add_instr(enc_i(op_sw, 8, 0, 16'h0144));
  // jal at word 57 calls word 62 and returns to word 59
  add_instr(enc_j(op_jal, 16));
  add_instr(enc_i(op_sw, 13, 0, 16'h0148));
  add_instr(enc_i(op_sw, 31, 0, 16'h014c));
  add_instr(enc_j(op_j, 20));
  add_instr(32'h0);
  add_instr(enc_i(op_sw, 12, 0, 16'h0150));
  add_instr(enc_i(op_jr, 0, 31, 0));
  add_instr(enc_i(op_sw, 14, 0, 16'h0154));
  add_instr(enc_i(op_sw, 15, 0, 16'h01e8));
  // marker store and a spin
  add_instr(enc_i(op_lhi, 5, 0, 16'h600d));
  add_instr(enc_i(op_ori, 5, 5, 16'hf00d));
  add_instr(enc_i(op_sw, 5, 0, 16'h01fc));
  add_instr(enc_j(op_j, -4));
  add_instr(32'h0);
  // expected stores
  add_store(32'h100, 32'h00000245, 2'b00);
  add_store(32'h104, 32'h000070f0, 2'b00);
  add_store(32'h108, 32'h00006fce, 2'b00);
  add_store(32'h10c, 32'hf0001230, 2'b00);
  add_store(32'h110, 32'h80000001, 2'b00);
  add_store(32'h114, 32'h0000007f, 2'b00);
  add_store(32'h118, 32'hffffff81, 2'b00);
  add_store(32'h11c, 32'h000000c3, 2'b00);
  add_store(32'h120, 32'hffffc3a5, 2'b00);
  add_store(32'h124, 32'h0000c3a5, 2'b00);
  add_store(32'h128, 32'h00008026, 2'b00);
  add_store(32'h12c, 32'hc3a57f81, 2'b00);
  add_store(32'h201, 32'h00000123, 2'b10);
  add_store(32'h202, 32'h00008001, 2'b01);
  add_store(32'h130, 32'h80012381, 2'b00);
  add_store(32'h134, 32'h00000245, 2'b00);
  add_store(32'h138, 32'h00007ffe, 2'b00);
  add_store(32'h13c, 32'h00006fce, 2'b00);
  add_store(32'h140, 32'h00001210, 2'b00);
  add_store(32'h144, 32'h00000001, 2'b00);
  add_store(32'h148, 32'h08000000, 2'b00);
  add_store(32'h150, 32'h00000004, 2'b00);
  add_store(32'h154, 32'h00001230, 2'b00);
  add_store(32'h14c, 32'h000000ec, 2'b00);
  add_store(32'h1fc, 32'h600df00d, 2'b00);
endtask

`endif

/* sim/tb_dlx_pipeline.sv */
`timescale 1ns/1ps

module tb_dlx_pipeline;
  import dlx_pkg::*;

  logic clk;
  logic rst;
  logic [word_w-1:0] instruction;
  logic [word_w-1:0] mem_read_data;
  logic [word_w-1:0] pc;
  logic [word_w-1:0] mem_addr;
  logic [word_w-1:0] mem_write_data;
  logic mem_wr;
  logic mem_sb;
  logic mem_sh;

  // instruction and data memories, word addressed
  logic [word_w-1:0] prog [0:127];
  logic [word_w-1:0] dmem [0:255];
  int n_seen;
  int cycles;
  int limit;
  int extra;

  `include "tb_program.svh"

  dlx_pipeline uut (
    .clk(clk), .rst(rst), .instruction(instruction), .mem_read_data(mem_read_data),
    .pc(pc), .mem_addr(mem_addr), .mem_write_data(mem_write_data),
    .mem_wr(mem_wr), .mem_sb(mem_sb), .mem_sh(mem_sh)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // both memories answer for the address held this cycle
  always begin
    @(posedge clk);
    #1;
    instruction = prog[pc[8:2]];
    mem_read_data = dmem[mem_addr[9:2]];
  end

  ////////////////////
  // checks
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input logic [word_w-1:0] expected,
                            input logic [word_w-1:0] actual);
    if (actual !== expected)
      fail_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
  endtask

  // pair is {mem_sb, mem_sh}
  task automatic check_size(input string name, input logic [1:0] expected,
                            input logic [1:0] actual);
    if (actual !== expected)
      fail_run($sformatf("FAILED %s expected %b actual %b", name, expected, actual));
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      fail_run($sformatf("FAILED %s expected %b actual %b", name, expected, actual));
  endtask

  // lane merge, little endian
  task automatic apply_store();
    if (mem_sb)
      dmem[mem_addr[9:2]][{mem_addr[1:0], 3'b000} +: 8] = mem_write_data[7:0];
    else if (mem_sh)
      dmem[mem_addr[9:2]][{mem_addr[1], 4'b0000} +: 16] = mem_write_data[15:0];
    else
      dmem[mem_addr[9:2]] = mem_write_data;
  endtask

  ////////////////////
  // main sequence
  initial begin
    rst = 1'b1;
    instruction = '0;
    mem_read_data = '0;
    n_seen = 0;
    cycles = 0;
    extra = 0;
    init_tables();
    limit = 8 * n_prog + 50;
    // five reset cycles plus the one after
    for (int k = 0; k < 5; k++) begin
      @(posedge clk);
      if (k == 4)
        #1 rst = 1'b0;
      @(negedge clk);
      check_word($sformatf("reset pc %0d", k), '0, pc);
      check_flag($sformatf("reset mem_wr %0d", k), 1'b0, mem_wr);
    end
    // one table entry per store
    while (n_seen < n_exp) begin
      @(negedge clk);
      cycles++;
      if (cycles > limit)
        fail_run($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
                           cycles, n_seen, n_exp));
      if (mem_wr) begin
        check_word($sformatf("store %0d addr", n_seen), exp_addr[n_seen], mem_addr);
        check_word($sformatf("store %0d data", n_seen), exp_data[n_seen], mem_write_data);
        check_size($sformatf("store %0d size", n_seen), exp_size[n_seen], {mem_sb, mem_sh});
        apply_store();
        n_seen++;
      end
    end
    // core spins after the marker
    repeat (20) begin
      @(negedge clk);
      if (mem_wr)
        extra++;
    end
    if (extra == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      fail_run($sformatf("%0d stores appeared after the marker store", extra));
    end
  end

endmodule

/* compile.f */
+incdir+sim
hw/dlx_pkg.sv
hw/dlx_fetch.sv
hw/dlx_decode.sv
hw/dlx_reg_file.sv
hw/dlx_hazard.sv
hw/dlx_execute.sv
hw/dlx_write_back.sv
hw/dlx_pipeline.sv
sim/tb_dlx_pipeline.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f compile.f \
	  --top-module tb_dlx_pipeline

obj_dir/tb_dlx_pipeline: compile.f hw/*.sv sim/*.sv sim/*.svh
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
	  --top-module tb_dlx_pipeline -o tb_dlx_pipeline

sim: obj_dir/tb_dlx_pipeline
	-./obj_dir/tb_dlx_pipeline > sim.log 2>&1
	@cat sim.log
	@grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
